/* eth_frame_pkg.sv */
package eth_frame_pkg;

    // Ethernet header
    localparam logic [15:0] ETHER_TYPE_IPV4 = 16'h0800;

    // IPv4 header fields that never change
    localparam logic [3:0] IP_VERSION = 4'd4;
    localparam logic [3:0] IP_IHL = 4'd5;
    localparam logic [7:0] IP_TOS = 8'h00;
    localparam logic [7:0] IP_TTL = 8'hFF;
    localparam logic [7:0] IP_PROTO_UDP = 8'h11;

    // Fixed payload size in bytes
    localparam int DATA_BYTES = 8;

    // Header sizes in bytes
    localparam int MAC_HEADER_BYTES = 14;
    localparam int IP_HEADER_BYTES = 20;
    localparam int UDP_HEADER_BYTES = 8;

    // Length fields carried in the IP and UDP headers
    localparam int UDP_TOTAL_BYTES = UDP_HEADER_BYTES + DATA_BYTES;
    localparam int IP_TOTAL_BYTES = IP_HEADER_BYTES + UDP_TOTAL_BYTES;

    // Zero bytes so the frame is a multiple of 4 bytes long
    localparam int PAD_BYTES = (4 - ((MAC_HEADER_BYTES + IP_TOTAL_BYTES) % 4)) % 4;

    // Frame without preamble and FCS
    localparam int FRAME_BYTES = MAC_HEADER_BYTES + IP_TOTAL_BYTES + PAD_BYTES;
    localparam int FRAME_BITS = 8 * FRAME_BYTES;

    // Byte offsets in wire order, byte 0 sits in the top bits of the frame
    localparam int IP_OFFSET = MAC_HEADER_BYTES;
    localparam int UDP_OFFSET = IP_OFFSET + IP_HEADER_BYTES;
    localparam int DATA_OFFSET = UDP_OFFSET + UDP_HEADER_BYTES;
    localparam int IP_CSUM_OFFSET = IP_OFFSET + 10;
    localparam int UDP_CSUM_OFFSET = UDP_OFFSET + 6;

    // Line side lengths in nibbles
    localparam int PREAMBLE_NIBBLES = 16;
    localparam int FRAME_NIBBLES = 2 * FRAME_BYTES;
    localparam int FCS_NIBBLES = 8;
    localparam int GAP_NIBBLES = 24;

    // Normal form of the IEEE 802.3 polynomial
    localparam logic [31:0] CRC_POLY = 32'h04C11DB7;

    // Field widths
    localparam int MAC_W = 48;
    localparam int IP_W = 32;
    localparam int PORT_W = 16;
    localparam int WORD_W = 16;

endpackage

/* udp_tx_pkg.sv */
package udp_tx_pkg;

    // Top level sequencing
    typedef enum logic [1:0] {
        IDLE,
        BUILD,
        SEND,
        GAP
    } tx_state_t;

    // Checksum build steps
    typedef enum logic [2:0] {
        ASM_IDLE,
        ASM_IP_SUM,
        ASM_IP_DONE,
        ASM_UDP_SUM,
        ASM_UDP_DONE
    } asm_step_t;

    // IP header words without the checksum field
    localparam int IP_SUM_WORDS = 9;

    // Pseudo header, UDP header, then payload plus pad
    localparam int UDP_SUM_WORDS =
        6 + 3 + (eth_frame_pkg::DATA_BYTES + eth_frame_pkg::PAD_BYTES) / 2;

    // Whole burst with tx_en high
    localparam int TOTAL_NIBBLES = eth_frame_pkg::PREAMBLE_NIBBLES +
        eth_frame_pkg::FRAME_NIBBLES + eth_frame_pkg::FCS_NIBBLES;

    localparam int NIB_CNT_W = $clog2(TOTAL_NIBBLES + 1);
    localparam int GAP_CNT_W = $clog2(eth_frame_pkg::GAP_NIBBLES);
    localparam int WORD_CNT_W = $clog2(UDP_SUM_WORDS);

endpackage

/* inet_checksum.sv */
`timescale 1ns/1ps

module inet_checksum (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              sum_clear,
    input  logic                              word_valid,
    input  logic [eth_frame_pkg::WORD_W-1:0]  word,
    output logic [eth_frame_pkg::WORD_W-1:0]  checksum
);

    // Plain sum with the carries folded in at the output
    logic [31:0] acc;
    logic [16:0] fold_1;
    logic [16:0] fold_2;

    always_ff @(posedge clk) begin
        if (reset) begin
            acc <= '0;
        end else if (sum_clear) begin
            acc <= '0;
        end else if (word_valid) begin
            acc <= acc + {16'h0000, word};
        end
    end

    // First fold can carry once more
    assign fold_1 = {1'b0, acc[31:16]} + {1'b0, acc[15:0]};

    // Second fold cannot carry
    assign fold_2 = {1'b0, fold_1[15:0]} + {16'h0000, fold_1[16]};

    // Ones' complement of the ones' complement sum
    assign checksum = ~fold_2[15:0];

endmodule

/* udp_frame_assembler.sv */
`timescale 1ns/1ps

module udp_frame_assembler (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  build_start,
    input  logic [eth_frame_pkg::MAC_W-1:0]       src_mac,
    input  logic [eth_frame_pkg::MAC_W-1:0]       dest_mac,
    input  logic [eth_frame_pkg::IP_W-1:0]        src_ip,
    input  logic [eth_frame_pkg::IP_W-1:0]        dest_ip,
    input  logic [eth_frame_pkg::PORT_W-1:0]      src_port,
    input  logic [eth_frame_pkg::PORT_W-1:0]      dest_port,
    input  logic [8*eth_frame_pkg::DATA_BYTES-1:0] payload,
    input  logic [eth_frame_pkg::WORD_W-1:0]      checksum,
    output logic                                  sum_clear,
    output logic                                  word_valid,
    output logic [eth_frame_pkg::WORD_W-1:0]      word,
    output logic [eth_frame_pkg::FRAME_BITS-1:0]  frame,
    output logic                                  build_done
);
    import eth_frame_pkg::*;
    import udp_tx_pkg::*;

    asm_step_t step;
    logic [WORD_CNT_W-1:0] word_cnt;
    int unsigned word_off;
    logic mask_hi;
    logic [WORD_W-1:0] raw_word;

    assign word_valid = (step == ASM_IP_SUM) || (step == ASM_UDP_SUM);

    // Clear at the start and again between the two sums
    assign sum_clear = build_start || (step == ASM_IP_DONE);
    assign build_done = (step == ASM_UDP_DONE);

    // Byte offset of the word fed this cycle
    always_comb begin
        word_off = IP_OFFSET;
        mask_hi = 1'b0;
        if (step == ASM_IP_SUM) begin
            // Step over the checksum field after word four
            word_off = IP_OFFSET + 2 * word_cnt + (word_cnt >= 5 ? 2 : 0);
        end else if (word_cnt < 4) begin
            // Pseudo header addresses
            word_off = IP_OFFSET + 12 + 2 * word_cnt;
        end else if (word_cnt == 4) begin
            // Zero byte and protocol with the TTL masked off
            word_off = IP_OFFSET + 8;
            mask_hi = 1'b1;
        end else if (word_cnt == 5) begin
            // Pseudo header copy of the UDP length
            word_off = UDP_OFFSET + 4;
        end else if (word_cnt < 9) begin
            // Ports and length without the checksum field
            word_off = UDP_OFFSET + 2 * (word_cnt - 6);
        end else begin
            word_off = DATA_OFFSET + 2 * (word_cnt - 9);
        end
    end

    assign raw_word = frame[FRAME_BITS - 1 - 8 * word_off -: WORD_W];
    assign word = mask_hi ? {8'h00, raw_word[7:0]} : raw_word;

    always_ff @(posedge clk) begin
        if (reset) begin
            step <= ASM_IDLE;
            word_cnt <= '0;
        end else begin
            case (step)
                ASM_IDLE: begin
                    if (build_start) begin
                        step <= ASM_IP_SUM;
                        word_cnt <= '0;
                    end
                end
                ASM_IP_SUM: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (word_cnt == WORD_CNT_W'(IP_SUM_WORDS - 1)) begin
                        step <= ASM_IP_DONE;
                    end
                end
                ASM_IP_DONE: begin
                    step <= ASM_UDP_SUM;
                    word_cnt <= '0;
                end
                ASM_UDP_SUM: begin
                    word_cnt <= word_cnt + 1'b1;
                    if (word_cnt == WORD_CNT_W'(UDP_SUM_WORDS - 1)) begin
                        step <= ASM_UDP_DONE;
                    end
                end
                default: begin
                    step <= ASM_IDLE;
                end
            endcase
        end
    end

    // Frame register holds the fields in wire order with zero checksums to start
    always_ff @(posedge clk) begin
        if (build_start) begin
            frame <= {
                dest_mac, src_mac, ETHER_TYPE_IPV4,
                IP_VERSION, IP_IHL, IP_TOS, 16'(IP_TOTAL_BYTES),
                16'h0000, 16'h0000,
                IP_TTL, IP_PROTO_UDP, 16'h0000,
                src_ip, dest_ip,
                src_port, dest_port, 16'(UDP_TOTAL_BYTES), 16'h0000,
                payload, {(8 * PAD_BYTES){1'b0}}
            };
        end else if (step == ASM_IP_DONE) begin
            frame[FRAME_BITS - 1 - 8 * IP_CSUM_OFFSET -: WORD_W] <= checksum;
        end else if (step == ASM_UDP_DONE) begin
            frame[FRAME_BITS - 1 - 8 * UDP_CSUM_OFFSET -: WORD_W] <= checksum;
        end
    end

    // A new build only starts on an idle assembler
    assert property (@(posedge clk) disable iff (reset)
        build_start |-> (step == ASM_IDLE));

endmodule

/* fcs_crc32.sv */
`timescale 1ns/1ps

module fcs_crc32 (
    input  logic        clk,
    input  logic        reset,
    input  logic        crc_init,
    input  logic        nib_valid,
    input  logic [3:0]  nib,
    output logic [31:0] fcs
);
    import eth_frame_pkg::*;

    logic [31:0] crc;

    // Four shifts of the normal form CRC, data bit 0 enters first
    function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [3:0] d);
        logic [31:0] r;
        r = c;
        for (int j = 0; j < 4; j++) begin
            r = {r[30:0], 1'b0} ^ ((r[31] ^ d[j]) ? CRC_POLY : 32'h0);
        end
        return r;
    endfunction

    always_ff @(posedge clk) begin
        if (reset || crc_init) begin
            crc <= 32'hFFFFFFFF;
        end else if (nib_valid) begin
            crc <= crc_step(crc, nib);
        end
    end

    // Reflect to wire bit order and complement
    // Low nibble of fcs goes out first
    assign fcs = ~{<<{crc}};

endmodule

/* nibble_serializer.sv */
`timescale 1ns/1ps

module nibble_serializer (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 tx_start,
    input  logic [eth_frame_pkg::FRAME_BITS-1:0] frame,
    input  logic [31:0]                          fcs,
    output logic                                 crc_init,
    output logic                                 nib_valid,
    output logic [3:0]                           nib,
    output logic                                 tx_en,
    output logic [3:0]                           tx_d,
    output logic                                 tx_done
);
    import eth_frame_pkg::*;
    import udp_tx_pkg::*;

    logic busy;
    logic [NIB_CNT_W-1:0] cnt;
    logic [NIB_CNT_W-1:0] frame_idx;
    logic [NIB_CNT_W-1:0] fcs_idx;
    logic [3:0] tx_d_sel;

    // Positions inside the frame and FCS parts
    assign frame_idx = cnt - NIB_CNT_W'(PREAMBLE_NIBBLES);
    assign fcs_idx = cnt - NIB_CNT_W'(PREAMBLE_NIBBLES + FRAME_NIBBLES);

    // Bytes in wire order, low nibble of each byte first
    assign nib = frame[FRAME_BITS - 8 - 8 * (frame_idx >> 1) + 4 * frame_idx[0] +: 4];

    assign nib_valid = busy && (cnt >= NIB_CNT_W'(PREAMBLE_NIBBLES))
        && (cnt < NIB_CNT_W'(PREAMBLE_NIBBLES + FRAME_NIBBLES));

    // New CRC for every frame
    assign crc_init = tx_start;

    always_comb begin
        if (cnt < NIB_CNT_W'(PREAMBLE_NIBBLES - 1)) begin
            tx_d_sel = 4'h5;
        end else if (cnt == NIB_CNT_W'(PREAMBLE_NIBBLES - 1)) begin
            // SFD
            tx_d_sel = 4'hD;
        end else if (cnt < NIB_CNT_W'(PREAMBLE_NIBBLES + FRAME_NIBBLES)) begin
            tx_d_sel = nib;
        end else begin
            // CRC holds the last frame nibble by now
            tx_d_sel = fcs[4 * fcs_idx[2:0] +: 4];
        end
    end

    assign tx_en = busy;
    assign tx_d = busy ? tx_d_sel : 4'h0;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
            cnt <= '0;
            tx_done <= 1'b0;
        end else begin
            tx_done <= 1'b0;
            if (tx_start) begin
                busy <= 1'b1;
                cnt <= '0;
            end else if (busy) begin
                cnt <= cnt + 1'b1;
                // Last FCS nibble on the line this cycle
                if (cnt == NIB_CNT_W'(TOTAL_NIBBLES - 1)) begin
                    busy <= 1'b0;
                    tx_done <= 1'b1;
                end
            end
        end
    end

    // Burst only ends after the full preamble, frame and FCS
    assert property (@(posedge clk) disable iff (reset)
        $fell(tx_en) |-> (cnt == NIB_CNT_W'(TOTAL_NIBBLES)));

endmodule

/* udp_tx_control.sv */
`timescale 1ns/1ps

module udp_tx_control (
    input  logic clk,
    input  logic reset,
    input  logic send,
    input  logic build_done,
    input  logic tx_done,
    output logic ready,
    output logic build_start,
    output logic tx_start
);
    import eth_frame_pkg::*;
    import udp_tx_pkg::*;

    tx_state_t state;
    logic send_prev;
    logic [GAP_CNT_W-1:0] gap_cnt;

    // Send edges while busy are dropped
    assign build_start = send && !send_prev && ready;

    // Line side starts once both checksums are in the frame
    assign tx_start = (state == BUILD) && build_done;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
            // Held high so a send level at reset is not an edge
            send_prev <= 1'b1;
            ready <= 1'b0;
            gap_cnt <= '0;
        end else begin
            send_prev <= send;
            case (state)
                IDLE: begin
                    ready <= !build_start;
                    if (build_start) begin
                        state <= BUILD;
                    end
                end
                BUILD: begin
                    if (build_done) begin
                        state <= SEND;
                    end
                end
                SEND: begin
                    // tx_done marks the first idle line cycle
                    if (tx_done) begin
                        state <= GAP;
                        gap_cnt <= GAP_CNT_W'(1);
                    end
                end
                GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == GAP_CNT_W'(GAP_NIBBLES - 1)) begin
                        state <= IDLE;
                        ready <= 1'b1;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // A send is only taken in IDLE and ready drops on the next cycle
    assert property (@(posedge clk) disable iff (reset)
        build_start |-> (state == IDLE) ##1 !ready);

endmodule

/* udp_tx_top.sv */
`timescale 1ns/1ps

module udp_tx_top (
    input  logic                                   clk,
    input  logic                                   reset,
    input  logic                                   send,
    input  logic [eth_frame_pkg::MAC_W-1:0]        src_mac,
    input  logic [eth_frame_pkg::MAC_W-1:0]        dest_mac,
    input  logic [eth_frame_pkg::IP_W-1:0]         src_ip,
    input  logic [eth_frame_pkg::IP_W-1:0]         dest_ip,
    input  logic [eth_frame_pkg::PORT_W-1:0]       src_port,
    input  logic [eth_frame_pkg::PORT_W-1:0]       dest_port,
    input  logic [8*eth_frame_pkg::DATA_BYTES-1:0] payload,
    output logic                                   ready,
    output logic                                   tx_en,
    output logic [3:0]                             tx_d
);
    import eth_frame_pkg::*;

    // Control handshakes
    logic build_start;
    logic build_done;
    logic tx_start;
    logic tx_done;

    // Checksum unit
    logic sum_clear;
    logic word_valid;
    logic [WORD_W-1:0] word;
    logic [WORD_W-1:0] checksum;

    // Frame and CRC
    logic [FRAME_BITS-1:0] frame;
    logic crc_init;
    logic nib_valid;
    logic [3:0] nib;
    logic [31:0] fcs;

    udp_tx_control u_control (
        .clk(clk), .reset(reset), .send(send),
        .build_done(build_done), .tx_done(tx_done),
        .ready(ready), .build_start(build_start), .tx_start(tx_start)
    );

    udp_frame_assembler u_assembler (
        .clk(clk), .reset(reset), .build_start(build_start),
        .src_mac(src_mac), .dest_mac(dest_mac),
        .src_ip(src_ip), .dest_ip(dest_ip),
        .src_port(src_port), .dest_port(dest_port),
        .payload(payload), .checksum(checksum),
        .sum_clear(sum_clear), .word_valid(word_valid), .word(word),
        .frame(frame), .build_done(build_done)
    );

    inet_checksum u_checksum (
        .clk(clk), .reset(reset), .sum_clear(sum_clear),
        .word_valid(word_valid), .word(word), .checksum(checksum)
    );

    nibble_serializer u_serializer (
        .clk(clk), .reset(reset), .tx_start(tx_start),
        .frame(frame), .fcs(fcs),
        .crc_init(crc_init), .nib_valid(nib_valid), .nib(nib),
        .tx_en(tx_en), .tx_d(tx_d), .tx_done(tx_done)
    );

    fcs_crc32 u_crc (
        .clk(clk), .reset(reset), .crc_init(crc_init),
        .nib_valid(nib_valid), .nib(nib), .fcs(fcs)
    );

endmodule

/* tb_udp_tx.sv */
`timescale 1ns/1ps

module tb_udp_tx;
    import eth_frame_pkg::*;

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_FRAMES = 20;
    localparam int BURST_NIBBLES = PREAMBLE_NIBBLES + FRAME_NIBBLES + FCS_NIBBLES;
    // Burst, gap and build slack per frame
    localparam int WATCHDOG_CYCLES =
        NUM_FRAMES * (BURST_NIBBLES + GAP_NIBBLES + 80) + RESET_CYCLES;

    logic clk = 1'b0;
    logic reset;
    logic send;
    logic [MAC_W-1:0] src_mac;
    logic [MAC_W-1:0] dest_mac;
    logic [IP_W-1:0] src_ip;
    logic [IP_W-1:0] dest_ip;
    logic [PORT_W-1:0] src_port;
    logic [PORT_W-1:0] dest_port;
    logic [8*DATA_BYTES-1:0] payload;
    logic ready;
    logic tx_en;
    logic [3:0] tx_d;

    // Model output for each accepted send
    logic [7:0] exp_bytes[$];
    logic [31:0] exp_fcs[$];
    logic [3:0] cap_nib[$];
    logic [31:0] lfsr_state;
    logic tx_en_prev;
    logic ready_prev;
    logic gap_pending;
    int cycle;
    int fall_cycle;
    int frames_done;
    int gaps_checked;

    udp_tx_top dut (
        .clk(clk), .reset(reset), .send(send),
        .src_mac(src_mac), .dest_mac(dest_mac),
        .src_ip(src_ip), .dest_ip(dest_ip),
        .src_port(src_port), .dest_port(dest_port),
        .payload(payload), .ready(ready), .tx_en(tx_en), .tx_d(tx_d)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run();
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("mismatch %s expected %0h actual %0h", name, expected, actual);
            stop_run();
        end
    endtask

    // Taps 32, 22, 2, 1
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        return fb;
    endfunction

    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[62:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic string field_name(input int k);
        if (k < MAC_HEADER_BYTES) return "mac header";
        if (k < MAC_HEADER_BYTES + IP_HEADER_BYTES) return "ip header";
        if (k < MAC_HEADER_BYTES + IP_HEADER_BYTES + UDP_HEADER_BYTES) return "udp header";
        if (k < FRAME_BYTES - PAD_BYTES) return "payload";
        return "pad";
    endfunction

    // Ones' complement fold then invert
    function automatic logic [15:0] fold_invert(input logic [31:0] s);
        logic [31:0] r;
        r = s;
        while (r[31:16] != 16'h0000) begin
            r = {16'h0000, r[15:0]} + {16'h0000, r[31:16]};
        end
        return ~r[15:0];
    endfunction

    task automatic randomize_inputs();
        src_mac = MAC_W'(random_bits(MAC_W));
        dest_mac = MAC_W'(random_bits(MAC_W));
        src_ip = IP_W'(random_bits(IP_W));
        dest_ip = IP_W'(random_bits(IP_W));
        src_port = PORT_W'(random_bits(PORT_W));
        dest_port = PORT_W'(random_bits(PORT_W));
        payload = 64'(random_bits(8 * DATA_BYTES));
    endtask

    // Reference frame in wire order from the current inputs
    task automatic build_model();
        logic [7:0] b [FRAME_BYTES];
        logic [31:0] ip_sum;
        logic [31:0] udp_sum;
        logic [31:0] crc;
        logic [31:0] poly_r;
        logic [15:0] csum;
        int k;
        int j;
        for (k = 0; k < FRAME_BYTES; k++) begin
            b[k] = 8'h00;
        end
        for (k = 0; k < 6; k++) begin
            b[k] = dest_mac[47 - 8 * k -: 8];
            b[6 + k] = src_mac[47 - 8 * k -: 8];
        end
        b[12] = ETHER_TYPE_IPV4[15:8];
        b[13] = ETHER_TYPE_IPV4[7:0];
        b[14] = {IP_VERSION, IP_IHL};
        b[15] = IP_TOS;
        b[16] = 8'(IP_TOTAL_BYTES >> 8);
        b[17] = 8'(IP_TOTAL_BYTES);
        b[22] = IP_TTL;
        b[23] = IP_PROTO_UDP;
        for (k = 0; k < 4; k++) begin
            b[26 + k] = src_ip[31 - 8 * k -: 8];
            b[30 + k] = dest_ip[31 - 8 * k -: 8];
        end
        b[34] = src_port[15:8];
        b[35] = src_port[7:0];
        b[36] = dest_port[15:8];
        b[37] = dest_port[7:0];
        b[38] = 8'(UDP_TOTAL_BYTES >> 8);
        b[39] = 8'(UDP_TOTAL_BYTES);
        for (k = 0; k < DATA_BYTES; k++) begin
            b[42 + k] = payload[8 * DATA_BYTES - 1 - 8 * k -: 8];
        end
        // IP header words with the checksum still zero
        ip_sum = '0;
        for (k = 0; k < IP_HEADER_BYTES / 2; k++) begin
            ip_sum = ip_sum + {16'h0000, b[14 + 2 * k], b[15 + 2 * k]};
        end
        csum = fold_invert(ip_sum);
        b[24] = csum[15:8];
        b[25] = csum[7:0];
        // Pseudo header then UDP header, payload and pad
        udp_sum = {16'h0000, src_ip[31:16]} + {16'h0000, src_ip[15:0]};
        udp_sum = udp_sum + {16'h0000, dest_ip[31:16]} + {16'h0000, dest_ip[15:0]};
        udp_sum = udp_sum + {24'h000000, IP_PROTO_UDP} + {16'h0000, 16'(UDP_TOTAL_BYTES)};
        for (k = 0; k < (FRAME_BYTES - 34) / 2; k++) begin
            udp_sum = udp_sum + {16'h0000, b[34 + 2 * k], b[35 + 2 * k]};
        end
        csum = fold_invert(udp_sum);
        b[40] = csum[15:8];
        b[41] = csum[7:0];
        // Byte-wise reflected CRC-32
        for (k = 0; k < 32; k++) begin
            poly_r[k] = CRC_POLY[31 - k];
        end
        crc = 32'hFFFFFFFF;
        for (k = 0; k < FRAME_BYTES; k++) begin
            exp_bytes.push_back(b[k]);
            crc = crc ^ {24'h000000, b[k]};
            for (j = 0; j < 8; j++) begin
                crc = crc[0] ? ((crc >> 1) ^ poly_r) : (crc >> 1);
            end
        end
        exp_fcs.push_back(~crc);
    endtask

    task automatic check_burst();
        logic [31:0] fcs_want;
        string tag;
        int k;
        frames_done++;
        if (exp_fcs.size() == 0) begin
            $display("a frame went out with no accepted send behind it");
            stop_run();
        end
        tag = $sformatf("frame %0d", frames_done);
        check_value({tag, " burst length"}, 32'(BURST_NIBBLES), 32'(cap_nib.size()));
        for (k = 0; k < PREAMBLE_NIBBLES - 1; k++) begin
            check_value({tag, " preamble"}, 32'h5, 32'(cap_nib[k]));
        end
        check_value({tag, " sfd"}, 32'hD, 32'(cap_nib[PREAMBLE_NIBBLES - 1]));
        // Low nibble of each byte first
        for (k = 0; k < FRAME_BYTES; k++) begin
            check_value($sformatf("%s %s byte %0d", tag, field_name(k), k),
                32'(exp_bytes.pop_front()),
                32'({cap_nib[PREAMBLE_NIBBLES + 2 * k + 1], cap_nib[PREAMBLE_NIBBLES + 2 * k]}));
        end
        fcs_want = exp_fcs.pop_front();
        for (k = 0; k < FCS_NIBBLES; k++) begin
            check_value($sformatf("%s fcs nibble %0d", tag, k), 32'(fcs_want[4 * k +: 4]),
                32'(cap_nib[PREAMBLE_NIBBLES + FRAME_NIBBLES + k]));
        end
        cap_nib.delete();
    endtask

    // Line capture and gap timing on the falling edge
    always @(negedge clk) begin
        cycle++;
        if (tx_en) begin
            cap_nib.push_back(tx_d);
        end
        if (!tx_en && tx_en_prev) begin
            fall_cycle = cycle;
            gap_pending = 1'b1;
            check_burst();
        end
        if (ready && !ready_prev && gap_pending) begin
            check_value($sformatf("frame %0d gap", frames_done), 32'(GAP_NIBBLES),
                32'(cycle - fall_cycle));
            gap_pending = 1'b0;
            gaps_checked++;
        end
        tx_en_prev = tx_en;
        ready_prev = ready;
    end

    // Send edge while ready is low with new inputs that must not show up
    task automatic ignored_send();
        randomize_inputs();
        send = 1'b1;
        @(negedge clk);
        send = 1'b0;
    endtask

    task automatic send_frame();
        while (!ready) @(negedge clk);
        randomize_inputs();
        send = 1'b1;
        build_model();
        @(negedge clk);
        send = 1'b0;
        // Inputs change right after acceptance
        randomize_inputs();
        check_value("ready after accept", 32'h0, 32'(ready));
        @(negedge clk);
        ignored_send();
        while (!tx_en) @(negedge clk);
        repeat (int'(random_bits(6))) @(negedge clk);
        ignored_send();
        while (tx_en) @(negedge clk);
        // Pulse lands well inside the gap
        repeat (int'(random_bits(4))) @(negedge clk);
        check_value("ready in gap", 32'h0, 32'(ready));
        ignored_send();
        @(negedge clk);
    endtask

    initial begin
        #(CLK_PERIOD * WATCHDOG_CYCLES);
        $display("timeout, the frames did not all finish in the expected time");
        stop_run();
    end

    initial begin
        lfsr_state = 32'h85f1;
        reset = 1'b1;
        send = 1'b0;
        src_mac = '0;
        dest_mac = '0;
        src_ip = '0;
        dest_ip = '0;
        src_port = '0;
        dest_port = '0;
        payload = '0;
        tx_en_prev = 1'b0;
        ready_prev = 1'b0;
        gap_pending = 1'b0;
        cycle = 0;
        fall_cycle = 0;
        frames_done = 0;
        gaps_checked = 0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            check_value("tx_en in reset", 32'h0, 32'(tx_en));
            check_value("ready in reset", 32'h0, 32'(ready));
        end
        reset = 1'b0;
        @(negedge clk);
        check_value("ready after reset", 32'h1, 32'(ready));
        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame();
        end
        // Room for a stray frame to show up
        repeat (40) @(negedge clk);
        check_value("frame count", 32'(NUM_FRAMES), 32'(frames_done));
        check_value("gap count", 32'(NUM_FRAMES), 32'(gaps_checked));
        check_value("ready at end", 32'h1, 32'(ready));
        check_value("tx_en at end", 32'h0, 32'(tx_en));
        $display("TEST PASSED");
        $finish;
    end

endmodule

/* verilog.f */
eth_frame_pkg.sv
udp_tx_pkg.sv
inet_checksum.sv
udp_frame_assembler.sv
fcs_crc32.sv
nibble_serializer.sv
udp_tx_control.sv
udp_tx_top.sv
tb_udp_tx.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f verilog.f --top-module tb_udp_tx
out=$(./obj_dir/Vtb_udp_tx) || true
echo "$out"
echo "$out" | grep -q "TEST PASSED"
